// File: design/rv_consts.svh
/* data width, one-hot bundle widths and their bit positions */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN 64

// alu operation one-hot
`define ALU_W    12
`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_SLT  2
`define ALU_SLTU 3
`define ALU_XOR  4
`define ALU_OR   5
`define ALU_AND  6
`define ALU_SLL  7
`define ALU_SRL  8
`define ALU_SRA  9
`define ALU_ANDN 10
`define ALU_WRI  11

// branch and jump one-hot
`define BJ_W    8
`define BJ_BEQ  0
`define BJ_BNE  1
`define BJ_BLT  2
`define BJ_BGE  3
`define BJ_BLTU 4
`define BJ_BGEU 5
`define BJ_JALR 6
`define BJ_JAL  7

// load size and sign one-hot
`define LOAD_W   7
`define LOAD_LB  0
`define LOAD_LH  1
`define LOAD_LW  2
`define LOAD_LD  3
`define LOAD_LBU 4
`define LOAD_LHU 5
`define LOAD_LWU 6

// store size one-hot
`define SAVE_W  4
`define SAVE_SB 0
`define SAVE_SH 1
`define SAVE_SW 2
`define SAVE_SD 3

// writeback source one-hot
`define WB_W   3
`define WB_EXE 0
`define WB_MEM 1
`define WB_CSR 2

// exception bundle
`define EXCP_W      3
`define EXCP_ECALL  0
`define EXCP_EBREAK 1
`define EXCP_MRET   2

`endif

// File: design/isa_pkg.sv
/* architectural types: data word, instruction word, register and csr addresses */
`include "rv_consts.svh"

package isa_pkg;

  // one general purpose data word
  typedef logic [`XLEN-1:0] xlen_t;

  // raw 32-bit instruction
  typedef logic [31:0] inst_t;

  // x0..x31 index
  typedef logic [4:0] reg_addr_t;

  // csr address space
  typedef logic [11:0] csr_addr_t;

endpackage

// File: design/ctrl_pkg.sv
/* control bundle types and operand select encodings of the decode stage */
`include "rv_consts.svh"

package ctrl_pkg;

  typedef logic [`ALU_W-1:0]  alu_oh_t;
  typedef logic [`BJ_W-1:0]   bj_oh_t;
  typedef logic [`LOAD_W-1:0] load_oh_t;
  typedef logic [`SAVE_W-1:0] save_oh_t;
  typedef logic [`WB_W-1:0]   wb_oh_t;
  typedef logic [`EXCP_W-1:0] excp_t;

  // first execute operand
  typedef enum logic [2:0] {
    OP1_RS1,
    OP1_RS1_W,
    OP1_PC,
    OP1_ZERO,
    OP1_CSR
  } op1_sel_e;

  // second execute operand
  typedef enum logic [2:0] {
    OP2_IMM_I,
    OP2_IMM_S,
    OP2_IMM_U,
    OP2_RS2,
    OP2_RS2_W,
    OP2_FOUR,
    OP2_ZIMM,
    OP2_RS1
  } op2_sel_e;

  // jump offset format
  typedef enum logic [1:0] {
    JMP_NONE,
    JMP_B,
    JMP_J,
    JMP_I
  } jmp_sel_e;

endpackage

// File: design/dec_ctrl_if.sv
/* decoded control bundle, decoder to stage latch */
`timescale 1ns/1ps

interface dec_ctrl_if import ctrl_pkg::*; ();

  alu_oh_t  alu;
  bj_oh_t   bj;
  load_oh_t load;
  save_oh_t save;
  wb_oh_t   wb;
  excp_t    excp;

  logic     is_word;
  logic     mem_rd;
  logic     mem_wr;
  logic     rd_wen;
  logic     csr_wen;

  op1_sel_e op1_sel;
  op2_sel_e op2_sel;
  jmp_sel_e jmp_sel;

  logic     illegal;

  modport source (
    output alu, bj, load, save, wb, excp,
    output is_word, mem_rd, mem_wr, rd_wen, csr_wen,
    output op1_sel, op2_sel, jmp_sel, illegal
  );

  modport sink (
    input alu, bj, load, save, wb, excp,
    input is_word, mem_rd, mem_wr, rd_wen, csr_wen,
    input op1_sel, op2_sel, jmp_sel, illegal
  );

endinterface

// File: design/dec_fields_if.sv
/* register and csr addresses plus extended immediates of one instruction */
`timescale 1ns/1ps

interface dec_fields_if import isa_pkg::*; ();

  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  csr_addr_t csr_addr;

  // sign extended to the data width
  xlen_t     imm_i;
  xlen_t     imm_s;
  xlen_t     imm_b;
  xlen_t     imm_u;
  xlen_t     imm_j;

  // csr immediate, zero extended
  xlen_t     zimm;

  modport source (output rd, rs1, rs2, csr_addr, imm_i, imm_s, imm_b, imm_u, imm_j, zimm);

  modport sink (input rd, rs1, rs2, csr_addr, imm_i, imm_s, imm_b, imm_u, imm_j, zimm);

endinterface

// File: design/inst_decoder.sv
/* RV64I instruction classifier: one-hot control bundles, enables,
   operand selects and the illegal flag */
`timescale 1ns/1ps
`include "rv_consts.svh"

module inst_decoder import isa_pkg::*; import ctrl_pkg::*; (
  input inst_t       inst,
  dec_ctrl_if.source ctrl
);

  wire [6:0]  opcode = inst[6:0];
  wire [7:0]  f3_is  = 8'b1 << inst[14:12];
  wire        f6_00  = (inst[31:26] == 6'h00);
  wire        f6_10  = (inst[31:26] == 6'h10);
  wire        f7_00  = (inst[31:25] == 7'h00);
  wire        f7_20  = (inst[31:25] == 7'h20);
  wire [11:0] imm12  = inst[31:20];

  // major opcodes
  wire op_load   = (opcode == 7'h03);
  wire op_fence  = (opcode == 7'h0f);
  wire op_imm    = (opcode == 7'h13);
  wire op_auipc  = (opcode == 7'h17);
  wire op_imm_w  = (opcode == 7'h1b);
  wire op_store  = (opcode == 7'h23);
  wire op_reg    = (opcode == 7'h33);
  wire op_lui    = (opcode == 7'h37);
  wire op_reg_w  = (opcode == 7'h3b);
  wire op_branch = (opcode == 7'h63);
  wire op_jalr   = (opcode == 7'h67);
  wire op_jal    = (opcode == 7'h6f);
  wire op_system = (opcode == 7'h73);

  // 64-bit shifts carry a 6-bit shamt, so only func6 is fixed
  wire i_add  = op_imm & f3_is[0];
  wire i_sll  = op_imm & f3_is[1] & f6_00;
  wire i_slt  = op_imm & f3_is[2];
  wire i_sltu = op_imm & f3_is[3];
  wire i_xor  = op_imm & f3_is[4];
  wire i_srl  = op_imm & f3_is[5] & f6_00;
  wire i_sra  = op_imm & f3_is[5] & f6_10;
  wire i_or   = op_imm & f3_is[6];
  wire i_and  = op_imm & f3_is[7];

  wire iw_add = op_imm_w & f3_is[0];
  wire iw_sll = op_imm_w & f3_is[1] & f7_00;
  wire iw_srl = op_imm_w & f3_is[5] & f7_00;
  wire iw_sra = op_imm_w & f3_is[5] & f7_20;

  // register forms, func7 zero except sub and sra
  wire r_add  = op_reg & f3_is[0] & f7_00;
  wire r_sub  = op_reg & f3_is[0] & f7_20;
  wire r_sll  = op_reg & f3_is[1] & f7_00;
  wire r_slt  = op_reg & f3_is[2] & f7_00;
  wire r_sltu = op_reg & f3_is[3] & f7_00;
  wire r_xor  = op_reg & f3_is[4] & f7_00;
  wire r_srl  = op_reg & f3_is[5] & f7_00;
  wire r_sra  = op_reg & f3_is[5] & f7_20;
  wire r_or   = op_reg & f3_is[6] & f7_00;
  wire r_and  = op_reg & f3_is[7] & f7_00;

  wire rw_add = op_reg_w & f3_is[0] & f7_00;
  wire rw_sub = op_reg_w & f3_is[0] & f7_20;
  wire rw_sll = op_reg_w & f3_is[1] & f7_00;
  wire rw_srl = op_reg_w & f3_is[5] & f7_00;
  wire rw_sra = op_reg_w & f3_is[5] & f7_20;

  wire ld_any = op_load & ~f3_is[7];
  wire st_any = op_store & ~inst[14];
  wire jalr   = op_jalr & f3_is[0];
  wire fence  = op_fence & (f3_is[0] | f3_is[1]);

  wire sys0   = op_system & f3_is[0];
  wire ecall  = sys0 & (imm12 == 12'h000);
  wire ebreak = sys0 & (imm12 == 12'h001);
  wire mret   = sys0 & (imm12 == 12'h302);

  wire csrrw   = op_system & f3_is[1];
  wire csrrs   = op_system & f3_is[2];
  wire csrrc   = op_system & f3_is[3];
  wire csrrwi  = op_system & f3_is[5];
  wire csrrsi  = op_system & f3_is[6];
  wire csrrci  = op_system & f3_is[7];
  wire csr_imm = csrrwi | csrrsi | csrrci;
  wire csr_any = csrrw | csrrs | csrrc | csr_imm;

  alu_oh_t  alu;
  bj_oh_t   bj;
  load_oh_t load;
  save_oh_t save;
  excp_t    excp;

  always_comb begin
    bj[`BJ_BEQ]  = op_branch & f3_is[0];
    bj[`BJ_BNE]  = op_branch & f3_is[1];
    bj[`BJ_BLT]  = op_branch & f3_is[4];
    bj[`BJ_BGE]  = op_branch & f3_is[5];
    bj[`BJ_BLTU] = op_branch & f3_is[6];
    bj[`BJ_BGEU] = op_branch & f3_is[7];
    bj[`BJ_JALR] = jalr;
    bj[`BJ_JAL]  = op_jal;

    // address generation and link values all go through the adder
    alu[`ALU_ADD]  = i_add | iw_add | r_add | rw_add | op_lui | op_auipc
                   | ld_any | st_any | jalr | op_jal;
    alu[`ALU_SUB]  = r_sub | rw_sub;
    alu[`ALU_SLT]  = i_slt | r_slt | bj[`BJ_BLT] | bj[`BJ_BGE];
    alu[`ALU_SLTU] = i_sltu | r_sltu | bj[`BJ_BLTU] | bj[`BJ_BGEU];
    alu[`ALU_XOR]  = i_xor | r_xor | bj[`BJ_BEQ] | bj[`BJ_BNE];
    alu[`ALU_OR]   = i_or | r_or | csrrs | csrrsi;
    alu[`ALU_AND]  = i_and | r_and;
    alu[`ALU_SLL]  = i_sll | r_sll | iw_sll | rw_sll;
    alu[`ALU_SRL]  = i_srl | r_srl | iw_srl | rw_srl;
    alu[`ALU_SRA]  = i_sra | r_sra | iw_sra | rw_sra;
    alu[`ALU_ANDN] = csrrc | csrrci;
    alu[`ALU_WRI]  = csrrw | csrrwi;

    load[`LOAD_LB]  = op_load & f3_is[0];
    load[`LOAD_LH]  = op_load & f3_is[1];
    load[`LOAD_LW]  = op_load & f3_is[2];
    load[`LOAD_LD]  = op_load & f3_is[3];
    load[`LOAD_LBU] = op_load & f3_is[4];
    load[`LOAD_LHU] = op_load & f3_is[5];
    load[`LOAD_LWU] = op_load & f3_is[6];

    save[`SAVE_SB] = op_store & f3_is[0];
    save[`SAVE_SH] = op_store & f3_is[1];
    save[`SAVE_SW] = op_store & f3_is[2];
    save[`SAVE_SD] = op_store & f3_is[3];

    excp[`EXCP_ECALL]  = ecall;
    excp[`EXCP_EBREAK] = ebreak;
    excp[`EXCP_MRET]   = mret;
  end

  // every supported instruction except fence and system sets an alu bit
  wire legal = (|alu) | fence | (|excp);
  wire wr_rd = legal & (|alu) & ~st_any & ~(|bj[`BJ_BGEU:`BJ_BEQ]);

  assign ctrl.alu     = alu;
  assign ctrl.bj      = bj;
  assign ctrl.load    = load;
  assign ctrl.save    = save;
  assign ctrl.excp    = excp;
  assign ctrl.illegal = ~legal;
  assign ctrl.is_word = legal & (op_imm_w | op_reg_w);
  assign ctrl.mem_rd  = legal & ld_any;
  assign ctrl.mem_wr  = legal & st_any;
  assign ctrl.rd_wen  = wr_rd;
  assign ctrl.csr_wen = legal & csr_any;

  assign ctrl.wb[`WB_EXE] = wr_rd & ~ld_any & ~csr_any;
  assign ctrl.wb[`WB_MEM] = legal & ld_any;
  assign ctrl.wb[`WB_CSR] = legal & csr_any;

  assign ctrl.op1_sel = (op_imm_w | op_reg_w)          ? OP1_RS1_W :
                        (op_auipc | op_jal | op_jalr)  ? OP1_PC    :
                        op_system                      ? OP1_CSR   :
                        (op_lui | ~legal)              ? OP1_ZERO  : OP1_RS1;

  assign ctrl.op2_sel = op_reg_w                 ? OP2_RS2_W :
                        (op_reg | op_branch)     ? OP2_RS2   :
                        op_store                 ? OP2_IMM_S :
                        (op_lui | op_auipc)      ? OP2_IMM_U :
                        (op_jal | op_jalr)       ? OP2_FOUR  :
                        csr_imm                  ? OP2_ZIMM  :
                        csr_any                  ? OP2_RS1   : OP2_IMM_I;

  assign ctrl.jmp_sel = op_branch ? JMP_B :
                        op_jal    ? JMP_J :
                        op_jalr   ? JMP_I : JMP_NONE;

endmodule

// File: design/field_extract.sv
/* register and csr address slicing, immediate formation for all formats */
`timescale 1ns/1ps
`include "rv_consts.svh"

module field_extract import isa_pkg::*; (
  input  inst_t        inst,
  dec_fields_if.source fields,
  output reg_addr_t    rs1_addr,
  output reg_addr_t    rs2_addr,
  output csr_addr_t    csr_addr
);

  wire sign = inst[31];

  assign fields.rd       = inst[11:7];
  assign fields.rs1      = inst[19:15];
  assign fields.rs2      = inst[24:20];
  assign fields.csr_addr = inst[31:20];

  // read ports of the external register and csr files
  assign rs1_addr = fields.rs1;
  assign rs2_addr = fields.rs2;
  assign csr_addr = fields.csr_addr;

  assign fields.imm_i = {{(`XLEN-12){sign}}, inst[31:20]};
  assign fields.imm_s = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};

  // branch and jump offsets are halfword aligned
  assign fields.imm_b = {{(`XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
                         inst[11:8], 1'b0};
  assign fields.imm_j = {{(`XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                         inst[30:21], 1'b0};

  // upper immediate, sign extended from bit 31 as RV64 requires
  assign fields.imm_u = {{(`XLEN-32){sign}}, inst[31:12], 12'b0};

  // rs1 field reused as unsigned csr immediate
  assign fields.zimm = {{(`XLEN-5){1'b0}}, inst[19:15]};

endmodule

// File: design/id_latch.sv
/* decode stage output latch: valid/allowin handshake, operand and
   jump offset muxing, registered control and payload */
`timescale 1ns/1ps

module id_latch import isa_pkg::*; import ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        if_id_valid,
  input  logic        ex_allowin,
  output logic        id_allowin,
  output logic        id_ex_valid,
  input  xlen_t       pc_in,
  input  inst_t       inst_in,
  input  xlen_t       r_data1,
  input  xlen_t       r_data2,
  input  xlen_t       csr_data,
  dec_ctrl_if.sink    ctrl,
  dec_fields_if.sink  fields,
  output xlen_t       pc_out,
  output inst_t       inst_out,
  output xlen_t       ex_op1,
  output xlen_t       ex_op2,
  output xlen_t       jmp_imm,
  output xlen_t       rs2_data,
  output logic        is_word,
  output logic        mem_rd,
  output logic        mem_wr,
  output logic        rd_wen,
  output logic        csr_wen,
  output alu_oh_t     alu_info,
  output bj_oh_t      bj_info,
  output load_oh_t    load_info,
  output save_oh_t    save_info,
  output wb_oh_t      wb_sel,
  output excp_t       excp,
  output logic        illegal,
  output reg_addr_t   rd_addr,
  output csr_addr_t   csr_wr_addr
);

  logic  valid;
  logic  accept;
  xlen_t op1_mux;
  xlen_t op2_mux;
  xlen_t jmp_mux;

  // decode never stalls, so the slot frees as soon as execute takes it
  assign id_allowin  = !valid || ex_allowin;
  assign id_ex_valid = valid;
  assign accept      = if_id_valid && id_allowin;

  always_comb begin
    case (ctrl.op1_sel)
      OP1_RS1:   op1_mux = r_data1;
      OP1_RS1_W: op1_mux = xlen_t'(r_data1[31:0]);
      OP1_PC:    op1_mux = pc_in;
      OP1_CSR:   op1_mux = csr_data;
      default:   op1_mux = '0;
    endcase
  end

  always_comb begin
    case (ctrl.op2_sel)
      OP2_IMM_I: op2_mux = fields.imm_i;
      OP2_IMM_S: op2_mux = fields.imm_s;
      OP2_IMM_U: op2_mux = fields.imm_u;
      OP2_RS2:   op2_mux = r_data2;
      OP2_RS2_W: op2_mux = xlen_t'(r_data2[31:0]);
      OP2_FOUR:  op2_mux = xlen_t'(4);
      OP2_ZIMM:  op2_mux = fields.zimm;
      default:   op2_mux = r_data1;
    endcase
  end

  always_comb begin
    case (ctrl.jmp_sel)
      JMP_B:   jmp_mux = fields.imm_b;
      JMP_J:   jmp_mux = fields.imm_j;
      JMP_I:   jmp_mux = fields.imm_i;
      default: jmp_mux = '0;
    endcase
  end

  // valid bit and side-effect enables
  always_ff @(posedge clk) begin
    if (rst) begin
      valid   <= 1'b0;
      rd_wen  <= 1'b0;
      mem_rd  <= 1'b0;
      mem_wr  <= 1'b0;
      csr_wen <= 1'b0;
    end else begin
      if (id_allowin) begin
        valid <= if_id_valid;
      end
      if (accept) begin
        rd_wen  <= ctrl.rd_wen;
        mem_rd  <= ctrl.mem_rd;
        mem_wr  <= ctrl.mem_wr;
        csr_wen <= ctrl.csr_wen;
      end
    end
  end

  // payload, qualified by id_ex_valid downstream
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_out      <= pc_in;
      inst_out    <= inst_in;
      ex_op1      <= op1_mux;
      ex_op2      <= op2_mux;
      jmp_imm     <= jmp_mux;
      rs2_data    <= r_data2;
      is_word     <= ctrl.is_word;
      alu_info    <= ctrl.alu;
      bj_info     <= ctrl.bj;
      load_info   <= ctrl.load;
      save_info   <= ctrl.save;
      wb_sel      <= ctrl.wb;
      excp        <= ctrl.excp;
      illegal     <= ctrl.illegal;
      rd_addr     <= fields.rd;
      csr_wr_addr <= fields.csr_addr;
    end
  end

  // a stalled instruction stays put with its payload
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    (id_ex_valid && !ex_allowin) |=>
      (id_ex_valid && $stable(inst_out) && $stable(ex_op1)));

  // decoder never marks one instruction as both load and store
  a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr));

endmodule

// File: design/decode_stage.sv
/* decode stage top: decoder, field extractor and output latch */
`timescale 1ns/1ps

module decode_stage import isa_pkg::*; import ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      if_id_valid,
  input  logic      ex_allowin,
  output logic      id_allowin,
  output logic      id_ex_valid,
  input  xlen_t     pc_in,
  input  inst_t     inst_in,
  input  xlen_t     r_data1,
  input  xlen_t     r_data2,
  input  xlen_t     csr_data,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output csr_addr_t csr_addr,
  output xlen_t     pc_out,
  output inst_t     inst_out,
  output xlen_t     ex_op1,
  output xlen_t     ex_op2,
  output xlen_t     jmp_imm,
  output xlen_t     rs2_data,
  output logic      is_word,
  output logic      mem_rd,
  output logic      mem_wr,
  output logic      rd_wen,
  output logic      csr_wen,
  output alu_oh_t   alu_info,
  output bj_oh_t    bj_info,
  output load_oh_t  load_info,
  output save_oh_t  save_info,
  output wb_oh_t    wb_sel,
  output excp_t     excp,
  output logic      illegal,
  output reg_addr_t rd_addr,
  output csr_addr_t csr_wr_addr
);

  dec_ctrl_if   u_ctrl_if ();
  dec_fields_if u_fields_if ();

  inst_decoder u_inst_decoder (
    .inst (inst_in),
    .ctrl (u_ctrl_if)
  );

  // register file addresses leave combinationally for same-cycle read
  field_extract u_field_extract (
    .inst     (inst_in),
    .fields   (u_fields_if),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .csr_addr (csr_addr)
  );

  id_latch u_id_latch (
    .clk         (clk),
    .rst         (rst),
    .if_id_valid (if_id_valid),
    .ex_allowin  (ex_allowin),
    .id_allowin  (id_allowin),
    .id_ex_valid (id_ex_valid),
    .pc_in       (pc_in),
    .inst_in     (inst_in),
    .r_data1     (r_data1),
    .r_data2     (r_data2),
    .csr_data    (csr_data),
    .ctrl        (u_ctrl_if),
    .fields      (u_fields_if),
    .pc_out      (pc_out),
    .inst_out    (inst_out),
    .ex_op1      (ex_op1),
    .ex_op2      (ex_op2),
    .jmp_imm     (jmp_imm),
    .rs2_data    (rs2_data),
    .is_word     (is_word),
    .mem_rd      (mem_rd),
    .mem_wr      (mem_wr),
    .rd_wen      (rd_wen),
    .csr_wen     (csr_wen),
    .alu_info    (alu_info),
    .bj_info     (bj_info),
    .load_info   (load_info),
    .save_info   (save_info),
    .wb_sel      (wb_sel),
    .excp        (excp),
    .illegal     (illegal),
    .rd_addr     (rd_addr),
    .csr_wr_addr (csr_wr_addr)
  );

endmodule

// File: verification/tb_decode_stage.sv
/* decode stage testbench: random RV64I stimulus, register and csr file
   responder, reference decode model and output checks */
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_decode_stage import isa_pkg::*; import ctrl_pkg::*; ();

  localparam int CLK_HALF        = 50;
  localparam int RESET_CYCLES    = 8;
  localparam int N_INST          = 400;
  localparam int WATCHDOG_CYCLES = N_INST * 20;

  // expected latch contents for one accepted instruction
  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     jmp;
    xlen_t     rs2_data;
    logic      chk_ops;
    logic      chk_jmp;
    logic      is_word;
    logic      mem_rd;
    logic      mem_wr;
    logic      rd_wen;
    logic      csr_wen;
    logic      illegal;
    alu_oh_t   alu;
    bj_oh_t    bj;
    load_oh_t  load;
    save_oh_t  save;
    wb_oh_t    wb;
    excp_t     excp;
    reg_addr_t rd;
    csr_addr_t csr;
  } exp_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      if_id_valid;
  logic      ex_allowin;
  logic      id_allowin;
  logic      id_ex_valid;
  xlen_t     pc_in;
  inst_t     inst_in;
  xlen_t     r_data1;
  xlen_t     r_data2;
  xlen_t     csr_data;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  csr_addr_t csr_addr;
  xlen_t     pc_out;
  inst_t     inst_out;
  xlen_t     ex_op1;
  xlen_t     ex_op2;
  xlen_t     jmp_imm;
  xlen_t     rs2_data;
  logic      is_word;
  logic      mem_rd;
  logic      mem_wr;
  logic      rd_wen;
  logic      csr_wen;
  alu_oh_t   alu_info;
  bj_oh_t    bj_info;
  load_oh_t  load_info;
  save_oh_t  save_info;
  wb_oh_t    wb_sel;
  excp_t     excp;
  logic      illegal;
  reg_addr_t rd_addr;
  csr_addr_t csr_wr_addr;

  exp_t        exp_q[$];
  int          n_acc;
  int          n_out;
  xlen_t       pc_next;

  decode_stage u_decode_stage (.*);

  always #(CLK_HALF) clk = ~clk;

  // register file contents, x0 reads as zero
  function automatic xlen_t gpr_value(input reg_addr_t a);
    if (a == 5'd0) begin
      return '0;
    end else begin
      return (64'h9e37_79b9_7f4a_7c15 * 64'(a)) ^ 64'h0123_4567_89ab_cdef;
    end
  endfunction

  function automatic xlen_t csr_value(input csr_addr_t a);
    return (64'hc2b2_ae3d_27d4_eb4f * 64'(a)) + 64'h1656_67b1_9e37_79f9;
  endfunction

  // same-cycle read ports
  assign r_data1  = gpr_value(rs1_addr);
  assign r_data2  = gpr_value(rs2_addr);
  assign csr_data = csr_value(csr_addr);

  // widen the low nbits of v with its top bit
  function automatic xlen_t sext(input logic [31:0] v, input int unsigned nbits);
    xlen_t r;
    r = 64'(v);
    for (int i = nbits; i < 64; i++) begin
      r[i] = v[nbits-1];
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input xlen_t got, input xlen_t want);
    assert (got === want) else begin
      $display("FAIL %s: expected %h, got %h", name, want, got);
      abort_run();
    end
  endtask

  // legal words per class, with a few raw random words mixed in
  function automatic inst_t random_inst();
    inst_t       w;
    logic [31:0] r;
    w = $urandom;
    r = $urandom;
    if (r[31:24] < 8'd13) begin
      return w;
    end
    case (r[3:0])
      4'd0, 4'd1: begin
        w[6:0] = 7'h13;
        if (w[14:12] == 3'd1) begin
          w[31:26] = 6'h00;
        end
        if (w[14:12] == 3'd5) begin
          w[31:26] = r[12] ? 6'h10 : 6'h00;
        end
      end
      4'd2: begin
        w[6:0]   = 7'h1b;
        w[14:12] = (r[9:8] == 2'd0) ? 3'd1 : (r[9:8] == 2'd1) ? 3'd5 : 3'd0;
        if (w[14:12] != 3'd0) begin
          w[31:25] = (w[14:12] == 3'd5 && r[12]) ? 7'h20 : 7'h00;
        end
      end
      4'd3, 4'd4: begin
        w[6:0]   = 7'h33;
        w[31:25] = (r[12] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
      end
      4'd5: begin
        w[6:0]   = 7'h3b;
        w[14:12] = (r[9:8] == 2'd0) ? 3'd1 : (r[9:8] == 2'd1) ? 3'd5 : 3'd0;
        w[31:25] = (r[12] && w[14:12] != 3'd1) ? 7'h20 : 7'h00;
      end
      4'd6: w[6:0] = r[12] ? 7'h37 : 7'h17;
      4'd7, 4'd8: begin
        w[6:0] = 7'h03;
        if (w[14:12] == 3'd7) begin
          w[14:12] = 3'd3;
        end
      end
      4'd9: begin
        w[6:0] = 7'h23;
        w[14]  = 1'b0;
      end
      4'd10, 4'd11: begin
        w[6:0] = 7'h63;
        // funct3 2 and 3 have no branch
        if (w[14:13] == 2'b01) begin
          w[14] = 1'b1;
        end
      end
      4'd12: begin
        w[6:0] = r[12] ? 7'h6f : 7'h67;
        if (!r[12]) begin
          w[14:12] = 3'd0;
        end
      end
      4'd13, 4'd14: begin
        w[6:0] = 7'h73;
        if (w[13:12] == 2'b00) begin
          w[13:12] = 2'b01;
        end
      end
      default: begin
        case (r[13:12])
          2'd0: w = 32'h0000_0073;
          2'd1: w = 32'h0010_0073;
          2'd2: w = 32'h3020_0073;
          default: begin
            w[6:0]   = 7'h0f;
            w[14:13] = 2'b00;
          end
        endcase
      end
    endcase
    return w;
  endfunction

  // reference decode following the RV64I opcode map
  function automatic exp_t ref_decode(input inst_t w, input xlen_t pc);
    exp_t       e;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      r1;
    xlen_t      r2;
    xlen_t      imm_i;
    logic       legal;
    logic       wb_exe;
    logic       wb_mem;
    logic       wb_csr;
    f3     = w[14:12];
    f7     = w[31:25];
    r1     = gpr_value(w[19:15]);
    r2     = gpr_value(w[24:20]);
    imm_i  = sext(32'(w[31:20]), 12);
    legal  = 1'b1;
    wb_exe = 1'b0;
    wb_mem = 1'b0;
    wb_csr = 1'b0;
    e          = '0;
    e.pc       = pc;
    e.inst     = w;
    e.rs2_data = r2;
    e.rd       = w[11:7];
    e.csr      = w[31:20];
    e.chk_ops  = 1'b1;
    e.chk_jmp  = 1'b1;
    case (w[6:0])
      7'h13: begin
        e.op1  = r1;
        e.op2  = imm_i;
        wb_exe = 1'b1;
        case (f3)
          3'd0: e.alu[`ALU_ADD] = 1'b1;
          3'd1: begin
            e.alu[`ALU_SLL] = 1'b1;
            legal = (f7[6:1] == 6'h00);
          end
          3'd2: e.alu[`ALU_SLT] = 1'b1;
          3'd3: e.alu[`ALU_SLTU] = 1'b1;
          3'd4: e.alu[`ALU_XOR] = 1'b1;
          3'd5: begin
            e.alu[`ALU_SRL] = (f7[6:1] == 6'h00);
            e.alu[`ALU_SRA] = (f7[6:1] == 6'h10);
            legal = e.alu[`ALU_SRL] | e.alu[`ALU_SRA];
          end
          3'd6: e.alu[`ALU_OR] = 1'b1;
          default: e.alu[`ALU_AND] = 1'b1;
        endcase
      end
      7'h1b, 7'h3b: begin
        // word forms use zero-extended low halves of the registers
        e.op1     = {32'b0, r1[31:0]};
        e.op2     = w[5] ? {32'b0, r2[31:0]} : imm_i;
        e.is_word = 1'b1;
        wb_exe    = 1'b1;
        e.alu[`ALU_ADD] = (f3 == 3'd0) && (!w[5] || f7 == 7'h00);
        e.alu[`ALU_SUB] = (f3 == 3'd0) && w[5] && (f7 == 7'h20);
        e.alu[`ALU_SLL] = (f3 == 3'd1) && (f7 == 7'h00);
        e.alu[`ALU_SRL] = (f3 == 3'd5) && (f7 == 7'h00);
        e.alu[`ALU_SRA] = (f3 == 3'd5) && (f7 == 7'h20);
        legal = |e.alu;
      end
      7'h33: begin
        e.op1  = r1;
        e.op2  = r2;
        wb_exe = 1'b1;
        if (f7 == 7'h00) begin
          e.alu[`ALU_ADD]  = (f3 == 3'd0);
          e.alu[`ALU_SLL]  = (f3 == 3'd1);
          e.alu[`ALU_SLT]  = (f3 == 3'd2);
          e.alu[`ALU_SLTU] = (f3 == 3'd3);
          e.alu[`ALU_XOR]  = (f3 == 3'd4);
          e.alu[`ALU_SRL]  = (f3 == 3'd5);
          e.alu[`ALU_OR]   = (f3 == 3'd6);
          e.alu[`ALU_AND]  = (f3 == 3'd7);
        end else if (f7 == 7'h20) begin
          e.alu[`ALU_SUB] = (f3 == 3'd0);
          e.alu[`ALU_SRA] = (f3 == 3'd5);
        end
        legal = |e.alu;
      end
      7'h37, 7'h17: begin
        e.op1  = w[5] ? '0 : pc;
        e.op2  = sext({w[31:12], 12'b0}, 32);
        wb_exe = 1'b1;
        e.alu[`ALU_ADD] = 1'b1;
      end
      7'h03: begin
        e.op1    = r1;
        e.op2    = imm_i;
        e.mem_rd = 1'b1;
        wb_mem   = 1'b1;
        e.alu[`ALU_ADD] = 1'b1;
        case (f3)
          3'd0: e.load[`LOAD_LB] = 1'b1;
          3'd1: e.load[`LOAD_LH] = 1'b1;
          3'd2: e.load[`LOAD_LW] = 1'b1;
          3'd3: e.load[`LOAD_LD] = 1'b1;
          3'd4: e.load[`LOAD_LBU] = 1'b1;
          3'd5: e.load[`LOAD_LHU] = 1'b1;
          3'd6: e.load[`LOAD_LWU] = 1'b1;
          default: legal = 1'b0;
        endcase
      end
      7'h23: begin
        e.op1    = r1;
        e.op2    = sext(32'({w[31:25], w[11:7]}), 12);
        e.mem_wr = 1'b1;
        e.alu[`ALU_ADD] = 1'b1;
        case (f3)
          3'd0: e.save[`SAVE_SB] = 1'b1;
          3'd1: e.save[`SAVE_SH] = 1'b1;
          3'd2: e.save[`SAVE_SW] = 1'b1;
          3'd3: e.save[`SAVE_SD] = 1'b1;
          default: legal = 1'b0;
        endcase
      end
      7'h63: begin
        e.op1 = r1;
        e.op2 = r2;
        e.jmp = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
        // compare result comes from xor, slt or sltu
        case (f3)
          3'd0: e.bj[`BJ_BEQ] = 1'b1;
          3'd1: e.bj[`BJ_BNE] = 1'b1;
          3'd4: e.bj[`BJ_BLT] = 1'b1;
          3'd5: e.bj[`BJ_BGE] = 1'b1;
          3'd6: e.bj[`BJ_BLTU] = 1'b1;
          3'd7: e.bj[`BJ_BGEU] = 1'b1;
          default: legal = 1'b0;
        endcase
        e.alu[`ALU_XOR]  = e.bj[`BJ_BEQ] | e.bj[`BJ_BNE];
        e.alu[`ALU_SLT]  = e.bj[`BJ_BLT] | e.bj[`BJ_BGE];
        e.alu[`ALU_SLTU] = e.bj[`BJ_BLTU] | e.bj[`BJ_BGEU];
      end
      7'h6f, 7'h67: begin
        // link value pc + 4
        e.op1  = pc;
        e.op2  = 64'd4;
        wb_exe = 1'b1;
        e.alu[`ALU_ADD] = 1'b1;
        e.bj[`BJ_JAL]   = w[3];
        e.bj[`BJ_JALR]  = !w[3];
        e.jmp = w[3] ? sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21) : imm_i;
        legal = w[3] || (f3 == 3'd0);
      end
      7'h0f: begin
        e.chk_ops = 1'b0;
        legal     = (f3[2:1] == 2'b00);
      end
      7'h73: begin
        e.op1 = csr_value(w[31:20]);
        e.op2 = f3[2] ? 64'(w[19:15]) : r1;
        if (f3 == 3'd0) begin
          e.chk_ops = 1'b0;
          e.excp[`EXCP_ECALL]  = (w[31:20] == 12'h000);
          e.excp[`EXCP_EBREAK] = (w[31:20] == 12'h001);
          e.excp[`EXCP_MRET]   = (w[31:20] == 12'h302);
          legal = |e.excp;
        end else begin
          wb_csr = 1'b1;
          e.alu[`ALU_WRI]  = (f3[1:0] == 2'd1);
          e.alu[`ALU_OR]   = (f3[1:0] == 2'd2);
          e.alu[`ALU_ANDN] = (f3[1:0] == 2'd3);
          legal = (f3 != 3'd4);
        end
      end
      default: legal = 1'b0;
    endcase
    if (legal) begin
      e.rd_wen        = wb_exe | wb_mem | wb_csr;
      e.csr_wen       = wb_csr;
      e.wb[`WB_EXE]   = wb_exe;
      e.wb[`WB_MEM]   = wb_mem;
      e.wb[`WB_CSR]   = wb_csr;
    end else begin
      e.alu     = '0;
      e.bj      = '0;
      e.load    = '0;
      e.save    = '0;
      e.excp    = '0;
      e.is_word = 1'b0;
      e.mem_rd  = 1'b0;
      e.mem_wr  = 1'b0;
      e.illegal = 1'b1;
      e.chk_ops = 1'b0;
      e.chk_jmp = 1'b0;
    end
    return e;
  endfunction

  task automatic compare_outputs(input exp_t e);
    check_value("pc_out", pc_out, e.pc);
    check_value("inst_out", 64'(inst_out), 64'(e.inst));
    check_value("rs2_data", rs2_data, e.rs2_data);
    check_value("rd_addr", 64'(rd_addr), 64'(e.rd));
    check_value("csr_wr_addr", 64'(csr_wr_addr), 64'(e.csr));
    check_value("illegal", 64'(illegal), 64'(e.illegal));
    check_value("is_word", 64'(is_word), 64'(e.is_word));
    check_value("mem_rd", 64'(mem_rd), 64'(e.mem_rd));
    check_value("mem_wr", 64'(mem_wr), 64'(e.mem_wr));
    check_value("rd_wen", 64'(rd_wen), 64'(e.rd_wen));
    check_value("csr_wen", 64'(csr_wen), 64'(e.csr_wen));
    check_value("alu_info", 64'(alu_info), 64'(e.alu));
    check_value("bj_info", 64'(bj_info), 64'(e.bj));
    check_value("load_info", 64'(load_info), 64'(e.load));
    check_value("save_info", 64'(save_info), 64'(e.save));
    check_value("wb_sel", 64'(wb_sel), 64'(e.wb));
    check_value("excp", 64'(excp), 64'(e.excp));
    if (e.chk_ops) begin
      check_value("ex_op1", ex_op1, e.op1);
      check_value("ex_op2", ex_op2, e.op2);
    end
    if (e.chk_jmp) begin
      check_value("jmp_imm", jmp_imm, e.jmp);
    end
  endtask

  // one clock: drive at the falling edge, then check and track the handshake
  task automatic run_cycle(input logic offer, input logic take);
    @(negedge clk);
    if_id_valid = offer;
    ex_allowin  = take;
    inst_in     = random_inst();
    pc_in       = pc_next;
    #1;
    check_value("id_ex_valid", 64'(id_ex_valid), 64'(exp_q.size() != 0));
    check_value("id_allowin", 64'(id_allowin), 64'(exp_q.size() == 0 || ex_allowin));
    // register and csr file read addresses
    check_value("rs1_addr", 64'(rs1_addr), 64'(inst_in[19:15]));
    check_value("rs2_addr", 64'(rs2_addr), 64'(inst_in[24:20]));
    check_value("csr_addr", 64'(csr_addr), 64'(inst_in[31:20]));
    if (id_ex_valid) begin
      compare_outputs(exp_q[0]);
      if (ex_allowin) begin
        exp_q.delete(0);
        n_out = n_out + 1;
      end
    end
    if (if_id_valid && id_allowin) begin
      exp_q.push_back(ref_decode(inst_in, pc_in));
      n_acc   = n_acc + 1;
      pc_next = pc_next + 64'd4;
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d instructions accepted", WATCHDOG_CYCLES, n_acc);
    abort_run();
  end

  initial begin
    void'($urandom(32'h4524));
    rst         = 1'b1;
    if_id_valid = 1'b0;
    ex_allowin  = 1'b0;
    pc_in       = '0;
    inst_in     = '0;
    n_acc       = 0;
    n_out       = 0;
    pc_next     = 64'h0000_0000_8000_0000;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_value("id_ex_valid", 64'(id_ex_valid), 64'd0);
    check_value("rd_wen", 64'(rd_wen), 64'd0);
    check_value("mem_rd", 64'(mem_rd), 64'd0);
    check_value("mem_wr", 64'(mem_wr), 64'd0);
    check_value("csr_wen", 64'(csr_wen), 64'd0);

    while (n_acc < N_INST) begin
      run_cycle(($urandom % 100) < 70, ($urandom % 100) < 70);
    end

    // drain the latch
    repeat (4) run_cycle(1'b0, 1'b1);

    if (exp_q.size() == 0 && n_out == n_acc && !id_ex_valid) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d instructions accepted but %0d delivered", n_acc, n_out);
      $display("Simulation failed");
      $fatal(1, "instruction count mismatch");
    end
  end

endmodule

// File: tb.f
+incdir+design
design/isa_pkg.sv
design/ctrl_pkg.sv
design/dec_ctrl_if.sv
design/dec_fields_if.sv
design/inst_decoder.sv
design/field_extract.sv
design/id_latch.sv
design/decode_stage.sv
verification/tb_decode_stage.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_decode_stage
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
